// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bt_link_tb
FILELIST = bt_link.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bt_link.f ====
bt_link_pkg.sv
fifo_ctrl_if.sv
word_to_byte_fifo.sv
byte_to_word_fifo.sv
uart_tx.sv
uart_rx.sv
bt_link_sequencer.sv
bt_link_top.sv
bt_link_tb.sv

// ==== bt_link_pkg.sv ====
`default_nettype none

package bt_link_pkg;

	// Sequencer states, in the order a session walks through them
	typedef enum logic [3:0] {
		IDLE,
		WAIT_DATA,
		LOAD_WORD,
		HOLD_WORD,
		POP_BYTE,
		WAIT_LINK,
		SEND_BYTE,
		CHECK_SENT,
		COLLECT_REPLY,
		WAIT_DEMAND,
		READ_WORD,
		OFFER_WORD,
		DONE
	} link_state_t;

	// 1 MHz clock into 38400 baud
	localparam int CLKS_PER_BIT = 26;
	localparam int CYC_W = $clog2(CLKS_PER_BIT);

	localparam int TX_DEPTH_WORDS = 16;
	localparam int TX_AW = $clog2(TX_DEPTH_WORDS);
	localparam int RX_DEPTH_BYTES = 32;
	localparam int RX_AW = $clog2(RX_DEPTH_BYTES);

	localparam int FRAME_WORDS = 5;
	// Must stay even, the host reads whole words
	localparam int REPLY_BYTES = 4;

	localparam int COUNT_W = 6;

endpackage

`default_nettype wire

// ==== bt_link_sequencer.sv ====
`default_nettype none

module bt_link_sequencer (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        begin_i,
	input  wire logic        command_mode_i,
	input  wire logic        host_load_i,
	input  wire logic        host_last_i,
	input  wire logic        host_seen_i,
	input  wire logic        read_req_i,
	input  wire logic        host_took_i,
	input  wire logic        host_finish_i,
	input  wire logic        bt_state_i,
	input  wire logic [15:0] sensor_sample_i,
	input  wire logic [15:0] host_word_i,
	input  wire logic        tx_done_i,
	output logic             bt_enable_o,
	output logic             stored_o,
	output logic             word_ready_o,
	output logic      [15:0] tx_word_o,
	output logic             tx_start_o,
	fifo_ctrl_if.sequencer   tx_fifo,
	fifo_ctrl_if.sequencer   rx_fifo
);

	bt_link_pkg::link_state_t state;
	bt_link_pkg::link_state_t next_state;
	logic cmd_mode;
	logic start_sent;
	logic frame_done;

	assign tx_word_o = cmd_mode ? host_word_i : sensor_sample_i;

	// Sensor frames end on the sample count, command frames on the host's flag
	always_comb
	begin
		if (cmd_mode)
			frame_done = host_last_i || tx_fifo.full;
		else
			frame_done = (tx_fifo.fill_count >= bt_link_pkg::COUNT_W'(bt_link_pkg::FRAME_WORDS))
				|| tx_fifo.full;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			bt_link_pkg::IDLE:
				if (begin_i)
					next_state = bt_link_pkg::WAIT_DATA;
			bt_link_pkg::WAIT_DATA:
				if (!cmd_mode || host_load_i)
					next_state = bt_link_pkg::LOAD_WORD;
			bt_link_pkg::LOAD_WORD:
				next_state = bt_link_pkg::HOLD_WORD;
			bt_link_pkg::HOLD_WORD:
				if (!cmd_mode || host_seen_i)
					next_state = frame_done ? bt_link_pkg::POP_BYTE : bt_link_pkg::WAIT_DATA;
			bt_link_pkg::POP_BYTE:
				next_state = cmd_mode ? bt_link_pkg::SEND_BYTE : bt_link_pkg::WAIT_LINK;
			bt_link_pkg::WAIT_LINK:
				if (bt_state_i)
					next_state = bt_link_pkg::SEND_BYTE;
			bt_link_pkg::SEND_BYTE:
				if (tx_done_i)
					next_state = bt_link_pkg::CHECK_SENT;
			bt_link_pkg::CHECK_SENT:
				if (!tx_fifo.empty)
					next_state = bt_link_pkg::POP_BYTE;
				else
					next_state = cmd_mode ? bt_link_pkg::COLLECT_REPLY : bt_link_pkg::DONE;
			bt_link_pkg::COLLECT_REPLY:
				if (rx_fifo.fill_count >= bt_link_pkg::COUNT_W'(bt_link_pkg::REPLY_BYTES))
					next_state = bt_link_pkg::WAIT_DEMAND;
			bt_link_pkg::WAIT_DEMAND:
				if (read_req_i && !rx_fifo.empty)
					next_state = bt_link_pkg::READ_WORD;
			bt_link_pkg::READ_WORD:
				next_state = bt_link_pkg::OFFER_WORD;
			bt_link_pkg::OFFER_WORD:
				if (host_took_i)
					next_state = host_finish_i ? bt_link_pkg::DONE : bt_link_pkg::WAIT_DEMAND;
			bt_link_pkg::DONE:
				if (!begin_i)
					next_state = bt_link_pkg::IDLE;
			default:
				next_state = bt_link_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= bt_link_pkg::IDLE;
			cmd_mode <= 1'b0;
			start_sent <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// Mode is frozen for the whole session
			if (state == bt_link_pkg::IDLE)
				cmd_mode <= command_mode_i;
			start_sent <= (state == bt_link_pkg::SEND_BYTE);
		end
	end

	assign tx_fifo.push = (state == bt_link_pkg::LOAD_WORD);
	assign tx_fifo.pop = (state == bt_link_pkg::POP_BYTE);
	assign rx_fifo.push = 1'b0;
	assign rx_fifo.pop = (state == bt_link_pkg::READ_WORD);

	// One start pulse on entry to SEND_BYTE
	assign tx_start_o = (state == bt_link_pkg::SEND_BYTE) && !start_sent;

	assign bt_enable_o = (state != bt_link_pkg::IDLE) && (state != bt_link_pkg::DONE);
	assign stored_o = (state == bt_link_pkg::HOLD_WORD) && cmd_mode;
	assign word_ready_o = (state == bt_link_pkg::OFFER_WORD);

endmodule

`default_nettype wire

// ==== bt_link_tb.sv ====
`default_nettype none

module bt_link_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int BIT_CYCLES = bt_link_pkg::CLKS_PER_BIT;
	localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
	localparam int FRAME = bt_link_pkg::FRAME_WORDS;
	// Longest wait for any single handshake
	localparam int WAIT_LIMIT = 4 * BYTE_CYCLES;
	// About 35 byte times of line traffic in the whole run
	localparam int RUN_CYCLES = 60 * BYTE_CYCLES + 2000;

	logic clock = 1'b0;
	logic reset;
	logic begin_i;
	logic command_mode_i;
	logic host_load_i;
	logic host_last_i;
	logic host_seen_i;
	logic read_req_i;
	logic host_took_i;
	logic host_finish_i;
	logic bt_state_i;
	logic rxd_i;
	logic [15:0] sensor_sample_i;
	logic [15:0] host_word_i;
	logic bt_enable_o;
	logic txd_o;
	logic stored_o;
	logic word_ready_o;
	logic [15:0] reply_word_o;
	int errors;
	int tests;

	always #(CLK_PERIOD / 2) clock = ~clock;

	bt_link_top bt_link_top_inst (.*);

	task automatic value_error(input string what, input logic [15:0] got, input logic [15:0] exp);
		$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - errors_before);
	endtask

	// Line model for txd_o, each bit sampled in its middle
	task automatic recv_tx_byte(output logic [7:0] value, output bit ok);
		int n;
		int i;
		n = 0;
		value = '0;
		ok = 1'b0;
		do
		begin
			@(negedge clock);
			n++;
		end
		while (txd_o !== 1'b0 && n < WAIT_LIMIT);
		if (txd_o !== 1'b0)
		begin
			report_problem("no start bit appeared on txd_o");
			return;
		end
		repeat (BIT_CYCLES / 2) @(negedge clock);
		if (txd_o !== 1'b0)
		begin
			report_problem("start bit on txd_o ended before mid-bit");
			return;
		end
		for (i = 0; i < 8; i++)
		begin
			repeat (BIT_CYCLES) @(negedge clock);
			value[i] = txd_o;
		end
		repeat (BIT_CYCLES) @(negedge clock);
		if (txd_o !== 1'b1)
			value_error("txd_o stop bit", 16'(txd_o), 16'd1);
		ok = 1'b1;
	endtask

	// Radio side of rxd_i, one 8N1 frame plus an idle bit
	task automatic send_rx_byte(input logic [7:0] value);
		int i;
		rxd_i = 1'b0;
		repeat (BIT_CYCLES) @(negedge clock);
		for (i = 0; i < 8; i++)
		begin
			rxd_i = value[i];
			repeat (BIT_CYCLES) @(negedge clock);
		end
		rxd_i = 1'b1;
		repeat (2 * BIT_CYCLES) @(negedge clock);
	endtask

	task automatic run_sensor_session(input bit stall);
		logic [15:0] samples [FRAME];
		logic [7:0] expected [2 * FRAME];
		logic [7:0] got;
		bit ok;
		int i;
		int n;
		int loads;
		int idle_breaks;
		int enable_drops;
		for (i = 0; i < FRAME; i++)
		begin
			// Top nibble keeps the samples distinct
			samples[i] = {4'(i + 1), 12'($urandom)};
			expected[2 * i] = samples[i][15:8];
			expected[2 * i + 1] = samples[i][7:0];
		end
		command_mode_i = 1'b0;
		sensor_sample_i = samples[0];
		bt_state_i = !stall;
		begin_i = 1'b1;
		loads = 0;
		fork
			begin
				// HOLD_WORD means the current sample was just stored
				n = 0;
				while (loads < FRAME && n < WAIT_LIMIT)
				begin
					@(negedge clock);
					n++;
					if (bt_link_top_inst.sequencer_inst.state == bt_link_pkg::HOLD_WORD)
					begin
						loads++;
						if (loads < FRAME)
							sensor_sample_i = samples[loads];
					end
				end
			end
			begin
				if (stall)
				begin
					idle_breaks = 0;
					enable_drops = 0;
					repeat (3 * BYTE_CYCLES)
					begin
						@(negedge clock);
						if (txd_o !== 1'b1)
							idle_breaks++;
						if (bt_enable_o !== 1'b1)
							enable_drops++;
					end
					if (idle_breaks != 0)
						report_problem("txd_o left idle while bt_state_i was low");
					if (enable_drops != 0)
						report_problem("bt_enable_o dropped while waiting for the link");
					bt_state_i = 1'b1;
				end
				for (i = 0; i < 2 * FRAME; i++)
				begin
					recv_tx_byte(got, ok);
					if (!ok)
						break;
					if (got !== expected[i])
						value_error($sformatf("sensor byte %0d", i), 16'(got), 16'(expected[i]));
					if (bt_enable_o !== 1'b1)
						value_error("bt_enable_o", 16'(bt_enable_o), 16'd1);
				end
			end
		join
		n = 0;
		while (bt_enable_o !== 1'b0 && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (bt_enable_o !== 1'b0)
			report_problem("sensor session never reached its end");
		begin_i = 1'b0;
		@(negedge clock);
	endtask

	task automatic reset_state_test();
		int errs;
		errs = errors;
		if (bt_enable_o !== 1'b0)
			value_error("bt_enable_o after reset", 16'(bt_enable_o), 16'd0);
		if (stored_o !== 1'b0)
			value_error("stored_o after reset", 16'(stored_o), 16'd0);
		if (word_ready_o !== 1'b0)
			value_error("word_ready_o after reset", 16'(word_ready_o), 16'd0);
		if (txd_o !== 1'b1)
			value_error("txd_o after reset", 16'(txd_o), 16'd1);
		finish_test("reset_state", errs);
	endtask

	task automatic sensor_frame_test();
		int errs;
		errs = errors;
		run_sensor_session(1'b1);
		finish_test("sensor_frame", errs);
	endtask

	task automatic command_transmit_test();
		logic [15:0] words [3];
		logic [7:0] expected [6];
		logic [7:0] got;
		bit ok;
		int errs;
		int i;
		int n;
		errs = errors;
		for (i = 0; i < 3; i++)
		begin
			words[i] = 16'($urandom);
			expected[2 * i] = words[i][15:8];
			expected[2 * i + 1] = words[i][7:0];
		end
		command_mode_i = 1'b1;
		begin_i = 1'b1;
		for (i = 0; i < 3; i++)
		begin
			host_word_i = words[i];
			host_last_i = (i == 2);
			host_load_i = 1'b1;
			n = 0;
			do
			begin
				@(negedge clock);
				n++;
			end
			while (stored_o !== 1'b1 && n < WAIT_LIMIT);
			host_load_i = 1'b0;
			if (stored_o !== 1'b1)
			begin
				report_problem($sformatf("stored_o never rose for command word %0d", i));
				break;
			end
			host_seen_i = 1'b1;
			@(negedge clock);
			host_seen_i = 1'b0;
			host_last_i = 1'b0;
		end
		for (i = 0; i < 6; i++)
		begin
			recv_tx_byte(got, ok);
			if (!ok)
				break;
			if (got !== expected[i])
				value_error($sformatf("command byte %0d", i), 16'(got), 16'(expected[i]));
		end
		finish_test("command_transmit", errs);
	endtask

	task automatic reply_readout_test();
		logic [7:0] reply [bt_link_pkg::REPLY_BYTES];
		int errs;
		int k;
		int n;
		errs = errors;
		for (k = 0; k < bt_link_pkg::REPLY_BYTES; k++)
		begin
			reply[k] = 8'($urandom);
			send_rx_byte(reply[k]);
		end
		for (k = 0; k < bt_link_pkg::REPLY_BYTES / 2; k++)
		begin
			read_req_i = 1'b1;
			n = 0;
			do
			begin
				@(negedge clock);
				n++;
			end
			while (word_ready_o !== 1'b1 && n < WAIT_LIMIT);
			read_req_i = 1'b0;
			if (word_ready_o !== 1'b1)
			begin
				report_problem($sformatf("word_ready_o never rose for reply word %0d", k));
				break;
			end
			// First byte on the line is the high byte
			if (reply_word_o !== {reply[2 * k], reply[2 * k + 1]})
				value_error($sformatf("reply word %0d", k), reply_word_o,
					{reply[2 * k], reply[2 * k + 1]});
			host_took_i = 1'b1;
			host_finish_i = (k == bt_link_pkg::REPLY_BYTES / 2 - 1);
			@(negedge clock);
			host_took_i = 1'b0;
			host_finish_i = 1'b0;
		end
		if (bt_enable_o !== 1'b0)
			value_error("bt_enable_o after the last reply word", 16'(bt_enable_o), 16'd0);
		finish_test("reply_readout", errs);
	endtask

	task automatic session_restart_test();
		int errs;
		errs = errors;
		begin_i = 1'b0;
		repeat (2) @(negedge clock);
		if (bt_enable_o !== 1'b0)
			value_error("bt_enable_o after begin_i fell", 16'(bt_enable_o), 16'd0);
		if (bt_link_top_inst.sequencer_inst.state != bt_link_pkg::IDLE)
			report_problem($sformatf("sequencer is in %s instead of IDLE",
				bt_link_top_inst.sequencer_inst.state.name()));
		run_sensor_session(1'b0);
		finish_test("session_restart", errs);
	endtask

	initial
	begin
		void'($urandom(32'h3210_50ea));
		errors = 0;
		tests = 0;
		reset = 1'b1;
		begin_i = 1'b0;
		command_mode_i = 1'b0;
		host_load_i = 1'b0;
		host_last_i = 1'b0;
		host_seen_i = 1'b0;
		read_req_i = 1'b0;
		host_took_i = 1'b0;
		host_finish_i = 1'b0;
		bt_state_i = 1'b0;
		rxd_i = 1'b1;
		sensor_sample_i = '0;
		host_word_i = '0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		reset_state_test();
		sensor_frame_test();
		command_transmit_test();
		reply_readout_test();
		session_restart_test();
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d clock cycles with the sequencer in %s",
			RUN_CYCLES, bt_link_top_inst.sequencer_inst.state.name());
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bt_link_top.sv ====
`default_nettype none

module bt_link_top (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        begin_i,
	input  wire logic        command_mode_i,
	input  wire logic        host_load_i,
	input  wire logic        host_last_i,
	input  wire logic        host_seen_i,
	input  wire logic        read_req_i,
	input  wire logic        host_took_i,
	input  wire logic        host_finish_i,
	input  wire logic        bt_state_i,
	input  wire logic        rxd_i,
	input  wire logic [15:0] sensor_sample_i,
	input  wire logic [15:0] host_word_i,
	output logic             bt_enable_o,
	output logic             txd_o,
	output logic             stored_o,
	output logic             word_ready_o,
	output logic      [15:0] reply_word_o
);

	logic [15:0] tx_word;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	logic tx_start;
	logic tx_done;
	logic rx_valid;

	fifo_ctrl_if tx_ctrl ();
	fifo_ctrl_if rx_ctrl ();

	word_to_byte_fifo tx_fifo_inst (
		.clock  (clock),
		.reset  (reset),
		.word_i (tx_word),
		.byte_o (tx_byte),
		.ctrl   (tx_ctrl.fifo)
	);

	// Receiver writes straight into the reply FIFO
	byte_to_word_fifo rx_fifo_inst (
		.clock        (clock),
		.reset        (reset),
		.byte_i       (rx_byte),
		.byte_valid_i (rx_valid),
		.word_o       (reply_word_o),
		.ctrl         (rx_ctrl.fifo)
	);

	uart_tx uart_tx_inst (
		.clock     (clock),
		.reset     (reset),
		.start_i   (tx_start),
		.data_i    (tx_byte),
		.txd_o     (txd_o),
		.tx_busy_o (),
		.tx_done_o (tx_done)
	);

	uart_rx uart_rx_inst (
		.clock      (clock),
		.reset      (reset),
		.rxd_i      (rxd_i),
		.rx_data_o  (rx_byte),
		.rx_valid_o (rx_valid)
	);

	bt_link_sequencer sequencer_inst (
		.clock           (clock),
		.reset           (reset),
		.begin_i         (begin_i),
		.command_mode_i  (command_mode_i),
		.host_load_i     (host_load_i),
		.host_last_i     (host_last_i),
		.host_seen_i     (host_seen_i),
		.read_req_i      (read_req_i),
		.host_took_i     (host_took_i),
		.host_finish_i   (host_finish_i),
		.bt_state_i      (bt_state_i),
		.sensor_sample_i (sensor_sample_i),
		.host_word_i     (host_word_i),
		.tx_done_i       (tx_done),
		.bt_enable_o     (bt_enable_o),
		.stored_o        (stored_o),
		.word_ready_o    (word_ready_o),
		.tx_word_o       (tx_word),
		.tx_start_o      (tx_start),
		.tx_fifo         (tx_ctrl.sequencer),
		.rx_fifo         (rx_ctrl.sequencer)
	);

endmodule

`default_nettype wire

// ==== byte_to_word_fifo.sv ====
`default_nettype none

module byte_to_word_fifo (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic [7:0] byte_i,
	input  wire logic       byte_valid_i,
	output logic     [15:0] word_o,
	fifo_ctrl_if.fifo       ctrl
);

	logic [7:0] mem [bt_link_pkg::RX_DEPTH_BYTES];
	logic [bt_link_pkg::RX_AW-1:0] wr_ptr;
	logic [bt_link_pkg::RX_AW-1:0] rd_ptr;
	logic [bt_link_pkg::COUNT_W-1:0] count;
	logic wr_en;

	// Bytes arriving on a full FIFO are dropped
	assign wr_en = byte_valid_i && !ctrl.full;

	assign ctrl.full = (count == bt_link_pkg::COUNT_W'(bt_link_pkg::RX_DEPTH_BYTES));
	assign ctrl.empty = (count == '0);
	assign ctrl.fill_count = count;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (ctrl.pop)
				rd_ptr <= rd_ptr + bt_link_pkg::RX_AW'(2);
			count <= count + wr_en - (ctrl.pop ? bt_link_pkg::COUNT_W'(2) : '0);
		end
	end

	// First byte received becomes the high byte
	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_ptr] <= byte_i;
		if (ctrl.pop)
			word_o <= {mem[rd_ptr], mem[rd_ptr + 1'b1]};
	end

	pop_needs_two_bytes: assert property (@(posedge clock) disable iff (reset)
		ctrl.pop |-> (count >= bt_link_pkg::COUNT_W'(2)));

	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		byte_valid_i |-> !ctrl.full);

endmodule

`default_nettype wire

// ==== fifo_ctrl_if.sv ====
`default_nettype none

// Control handshake between the sequencer and one FIFO
interface fifo_ctrl_if;

	logic push;
	logic pop;
	logic full;
	logic empty;
	logic [bt_link_pkg::COUNT_W-1:0] fill_count;

	modport sequencer (output push, output pop, input full, input empty, input fill_count);

	modport fifo (input push, input pop, output full, output empty, output fill_count);

endinterface

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic rxd_i,
	output logic [7:0] rx_data_o,
	output logic       rx_valid_o
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic [1:0] rxd_sync;
	logic rxd_prev;
	logic rx_line;
	logic fall;
	logic [bt_link_pkg::CYC_W-1:0] cyc;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic half_end;
	logic bit_end;

	assign rx_line = rxd_sync[1];
	assign fall = rxd_prev && !rx_line;
	assign half_end = (cyc == bt_link_pkg::CYC_W'(bt_link_pkg::CLKS_PER_BIT / 2 - 1));
	assign bit_end = (cyc == bt_link_pkg::CYC_W'(bt_link_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_sync <= 2'b11;
			rxd_prev <= 1'b1;
			state <= RX_IDLE;
			cyc <= '0;
			bit_idx <= '0;
			rx_valid_o <= 1'b0;
		end
		else
		begin
			rxd_sync <= {rxd_sync[0], rxd_i};
			rxd_prev <= rx_line;
			rx_valid_o <= 1'b0;
			cyc <= cyc + 1'b1;
			case (state)
				RX_IDLE:
				begin
					cyc <= '0;
					if (fall)
						state <= RX_START;
				end
				RX_START:
				begin
					// A glitch shorter than half a bit is ignored
					if (half_end)
					begin
						cyc <= '0;
						bit_idx <= '0;
						state <= rx_line ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						cyc <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					if (bit_end)
					begin
						rx_valid_o <= rx_line;
						state <= RX_IDLE;
					end
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Data bits sampled mid-bit, LSB first
	always_ff @(posedge clock)
	begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_line, shift[7:1]};
		if (state == RX_STOP && bit_end && rx_line)
			rx_data_o <= shift;
	end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic       start_i,
	input  wire logic [7:0] data_i,
	output logic            txd_o,
	output logic            tx_busy_o,
	output logic            tx_done_o
);

	// Stop bit, data LSB first, start bit in bit 0
	logic [9:0] frame;
	logic [3:0] bit_idx;
	logic [bt_link_pkg::CYC_W-1:0] cyc;
	logic bit_end;

	assign bit_end = (cyc == bt_link_pkg::CYC_W'(bt_link_pkg::CLKS_PER_BIT - 1));
	assign txd_o = tx_busy_o ? frame[0] : 1'b1;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame <= '1;
			bit_idx <= '0;
			cyc <= '0;
			tx_busy_o <= 1'b0;
			tx_done_o <= 1'b0;
		end
		else
		begin
			tx_done_o <= 1'b0;
			if (!tx_busy_o)
			begin
				if (start_i)
				begin
					frame <= {1'b1, data_i, 1'b0};
					bit_idx <= '0;
					cyc <= '0;
					tx_busy_o <= 1'b1;
				end
			end
			else if (bit_end)
			begin
				cyc <= '0;
				frame <= {1'b1, frame[9:1]};
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd9)
				begin
					tx_busy_o <= 1'b0;
					tx_done_o <= 1'b1;
				end
			end
			else
				cyc <= cyc + 1'b1;
		end
	end

	no_start_while_busy: assert property (@(posedge clock) disable iff (reset)
		start_i |-> !tx_busy_o);

endmodule

`default_nettype wire

// ==== word_to_byte_fifo.sv ====
`default_nettype none

module word_to_byte_fifo (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic [15:0] word_i,
	output logic      [7:0]  byte_o,
	fifo_ctrl_if.fifo        ctrl
);

	logic [15:0] mem [bt_link_pkg::TX_DEPTH_WORDS];
	logic [bt_link_pkg::TX_AW-1:0] wr_ptr;
	logic [bt_link_pkg::TX_AW-1:0] rd_ptr;
	// High when the high byte of the head word has gone out
	logic low_next;
	logic [bt_link_pkg::COUNT_W-1:0] count;
	logic word_freed;

	assign word_freed = ctrl.pop && low_next;

	assign ctrl.full = (count == bt_link_pkg::COUNT_W'(bt_link_pkg::TX_DEPTH_WORDS));
	assign ctrl.empty = (count == '0);
	assign ctrl.fill_count = count;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			low_next <= 1'b0;
			count <= '0;
		end
		else
		begin
			if (ctrl.push)
				wr_ptr <= wr_ptr + 1'b1;
			if (ctrl.pop)
				low_next <= !low_next;
			if (word_freed)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + ctrl.push - word_freed;
		end
	end

	// Storage and read data
	always_ff @(posedge clock)
	begin
		if (ctrl.push)
			mem[wr_ptr] <= word_i;
		if (ctrl.pop)
			byte_o <= low_next ? mem[rd_ptr][7:0] : mem[rd_ptr][15:8];
	end

	no_push_when_full: assert property (@(posedge clock) disable iff (reset)
		ctrl.push |-> !ctrl.full);

	no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
		ctrl.pop |-> !ctrl.empty);

endmodule

`default_nettype wire
